/* hdl/rv_isa_pkg.sv */
//----------------------------------------------------------
// RV32I opcode and funct encodings plus the ALU operation
// set shared by the decoder, the ALU and the testbench
//----------------------------------------------------------
package rv_isa_pkg;

    // ------------------------------------------------------
    // Major opcodes, low two bits always 2'b11
    // ------------------------------------------------------
    localparam logic [6:0] LOAD   = 7'b00_000_11;  // Not executed here, decodes as illegal
    localparam logic [6:0] OP_IMM = 7'b00_100_11;  // Register-immediate ALU ops
    localparam logic [6:0] AUIPC  = 7'b00_101_11;  // PC plus upper immediate
    localparam logic [6:0] OP     = 7'b01_100_11;  // Register-register ALU ops
    localparam logic [6:0] JALR   = 7'b11_001_11;  // Indirect jump, link value only
    localparam logic [6:0] JAL    = 7'b11_011_11;  // Direct jump, link value only

    // funct7 selects the alternate form of ADD and SRL
    localparam logic [6:0] F7_BASE = 7'b000_0000;  // ADD, SRL and the rest
    localparam logic [6:0] F7_ALT  = 7'b010_0000;  // SUB, SRA

    // ------------------------------------------------------
    // funct3 codes for OP and OP_IMM
    // ------------------------------------------------------
    localparam logic [2:0] F3_ADD  = 3'b000;       // ADD/SUB/ADDI, also JALR
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;       // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Operation handed from decode to the ALU datapath
    typedef enum logic [3:0] {
        ALU_ADD,                                   // Approximate when CSR allows
        ALU_SUB,                                   // Approximate when CSR allows
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_LINK,                                  // Operand 1 plus 4, always exact
        ALU_AUIPC,                                 // PC plus immediate, always exact
        ALU_NONE                                   // Illegal encoding
    } alu_op_t;

endpackage

/* hdl/apx_cfg_pkg.sv */
//----------------------------------------------------------
// Layout of the accuracy CSR and the default datapath and
// approximate widths used by the execute stage
//----------------------------------------------------------
package apx_cfg_pkg;

    // ------------------------------------------------------
    // Datapath sizes
    // ------------------------------------------------------
    localparam int XLEN            = 32;  // RV32 data width
    localparam int APX_LEN_DEFAULT = 8;   // Low adder bits that may go approximate

    // ------------------------------------------------------
    // Accuracy CSR fields
    // ------------------------------------------------------
    // bit 0                    : global enable
    // bit 1                    : reserved, reads back as written
    // bits ACC_MASK_LSB and up : one error-mask bit per low adder bit
    localparam int ACC_ENABLE_BIT = 0;    // Approximation on when set
    localparam int ACC_MASK_LSB   = 2;    // Mask bit for adder bit 0

endpackage

/* hdl/operand_select.sv */
//----------------------------------------------------------
// Instruction decode for the execute block: picks the ALU
// operation and both operands, flags unsupported encodings
//----------------------------------------------------------
`timescale 1ns/1ps

module operand_select #(
    parameter int XLEN = 32
) (
    input  logic [6:0]          opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [XLEN-1:0]     immediate,
    output rv_isa_pkg::alu_op_t alu_op,
    output logic [XLEN-1:0]     operand_1,
    output logic [XLEN-1:0]     operand_2,
    output logic                illegal_op
);

    // ------------------------------------------------------
    // Operand multiplexers
    // ------------------------------------------------------
    always_comb begin
        case (opcode)
            rv_isa_pkg::JAL,
            rv_isa_pkg::JALR,
            rv_isa_pkg::AUIPC: operand_1 = pc;            // Link and PC-relative
            default:           operand_1 = rs1;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::AUIPC: operand_2 = immediate;
            rv_isa_pkg::JAL,
            rv_isa_pkg::JALR:  operand_2 = XLEN'(4);      // Return address offset
            default:           operand_2 = rs2;           // OP and don't-care cases
        endcase
    end

    // ------------------------------------------------------
    // Operation decode
    // ------------------------------------------------------
    always_comb begin
        alu_op     = rv_isa_pkg::ALU_NONE;                // Fallback for anything unknown
        illegal_op = 1'b1;
        case (opcode)
            rv_isa_pkg::OP: begin
                illegal_op = 1'b0;
                if (funct7 == rv_isa_pkg::F7_ALT) begin   // Only SUB and SRA
                    if (funct3 == rv_isa_pkg::F3_ADD)     alu_op = rv_isa_pkg::ALU_SUB;
                    else if (funct3 == rv_isa_pkg::F3_SR) alu_op = rv_isa_pkg::ALU_SRA;
                    else                                  illegal_op = 1'b1;
                end else if (funct7 == rv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD:  alu_op = rv_isa_pkg::ALU_ADD;
                        rv_isa_pkg::F3_SLL:  alu_op = rv_isa_pkg::ALU_SLL;
                        rv_isa_pkg::F3_SLT:  alu_op = rv_isa_pkg::ALU_SLT;
                        rv_isa_pkg::F3_SLTU: alu_op = rv_isa_pkg::ALU_SLTU;
                        rv_isa_pkg::F3_XOR:  alu_op = rv_isa_pkg::ALU_XOR;
                        rv_isa_pkg::F3_SR:   alu_op = rv_isa_pkg::ALU_SRL;
                        rv_isa_pkg::F3_OR:   alu_op = rv_isa_pkg::ALU_OR;
                        default:             alu_op = rv_isa_pkg::ALU_AND;
                    endcase
                end else begin
                    illegal_op = 1'b1;                    // Unknown funct7
                end
            end
            rv_isa_pkg::OP_IMM: begin
                illegal_op = 1'b0;
                case (funct3)
                    rv_isa_pkg::F3_ADD:  alu_op = rv_isa_pkg::ALU_ADD;  // ADDI, can be approximate
                    rv_isa_pkg::F3_SLT:  alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: alu_op = rv_isa_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:   alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:  alu_op = rv_isa_pkg::ALU_AND;
                    rv_isa_pkg::F3_SLL: begin             // SLLI keeps funct7 clear
                        if (funct7 == rv_isa_pkg::F7_BASE) alu_op = rv_isa_pkg::ALU_SLL;
                        else                               illegal_op = 1'b1;
                    end
                    default: begin                        // SRLI or SRAI
                        if (funct7 == rv_isa_pkg::F7_BASE)     alu_op = rv_isa_pkg::ALU_SRL;
                        else if (funct7 == rv_isa_pkg::F7_ALT) alu_op = rv_isa_pkg::ALU_SRA;
                        else                                   illegal_op = 1'b1;
                    end
                endcase
            end
            rv_isa_pkg::JAL: begin
                alu_op     = rv_isa_pkg::ALU_LINK;
                illegal_op = 1'b0;
            end
            rv_isa_pkg::JALR: begin
                if (funct3 == rv_isa_pkg::F3_ADD) begin   // Only funct3 zero defined
                    alu_op     = rv_isa_pkg::ALU_LINK;
                    illegal_op = 1'b0;
                end
            end
            rv_isa_pkg::AUIPC: begin
                alu_op     = rv_isa_pkg::ALU_AUIPC;
                illegal_op = 1'b0;
            end
            default: ;                                    // Keeps ALU_NONE
        endcase

        // Flag and operation come from separate branches above
        assert (illegal_op == (alu_op == rv_isa_pkg::ALU_NONE))
            else $error("illegal_op disagrees with decoded alu_op");
    end

endmodule

/* hdl/apx_adder.sv */
//----------------------------------------------------------
// Ripple adder whose low APX_LEN bits can each drop their
// carry chain when the matching error-mask bit is set
//----------------------------------------------------------
`timescale 1ns/1ps

module apx_adder #(
    parameter int LEN     = 32,
    parameter int APX_LEN = 8
) (
    input  logic [LEN-1:0]     a,
    input  logic [LEN-1:0]     b,
    input  logic               carry_in,
    input  logic [APX_LEN-1:0] err_mask,
    output logic [LEN-1:0]     sum,
    output logic               carry_out
);

    // ------------------------------------------------------
    // Bit-serial carry chain
    // ------------------------------------------------------
    always_comb begin
        logic           c;                                // Carry entering bit i
        logic [LEN-1:0] mask_ext;                         // Upper bits never approximate
        logic [LEN:0]   exact;                            // Reference sum for the check

        mask_ext = LEN'(err_mask);
        c        = carry_in;                              // Bit 0 follows the same rule
        for (int i = 0; i < LEN; i++) begin
            if (mask_ext[i]) begin
                sum[i] = a[i] | b[i];                     // Incoming carry dropped
                c      = a[i] & b[i];                     // Generate only
            end else begin
                sum[i] = a[i] ^ b[i] ^ c;                 // Full adder
                c      = (a[i] & b[i]) | (c & (a[i] ^ b[i]));
            end
        end
        carry_out = c;

        // With no mask the ripple chain must equal true addition, carry included
        exact = (LEN+1)'(a) + (LEN+1)'(b) + (LEN+1)'(carry_in);
        if (err_mask == '0) begin
            assert ({carry_out, sum} == exact)
                else $error("exact adder mismatch a=%h b=%h cin=%b", a, b, carry_in);
        end
    end

endmodule

/* hdl/alu_apx.sv */
//----------------------------------------------------------
// Combinational RV32I ALU; ADD, ADDI and SUB go through the
// approximate adder, everything else is computed exactly
//----------------------------------------------------------
`timescale 1ns/1ps

module alu_apx #(
    parameter int XLEN    = 32,
    parameter int APX_LEN = 8
) (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] immediate,
    input  logic [XLEN-1:0] accuracy,                     // Accuracy CSR level
    output logic [XLEN-1:0] alu_result,
    output logic            illegal_op
);

    rv_isa_pkg::alu_op_t alu_op;                          // Decoded operation
    logic [XLEN-1:0]     operand_1;
    logic [XLEN-1:0]     operand_2;
    logic [XLEN-1:0]     adder_a;
    logic [XLEN-1:0]     adder_b;                         // Inverted for SUB
    logic                adder_cin;
    logic [XLEN-1:0]     sum;
    logic [APX_LEN-1:0]  csr_mask;                        // CSR mask gated by enable
    logic [APX_LEN-1:0]  err_mask;                        // Mask actually sent to adder
    logic [4:0]          shamt;

    operand_select #(
        .XLEN (XLEN)
    ) i_operand_select (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .immediate  (immediate),
        .alu_op     (alu_op),
        .operand_1  (operand_1),
        .operand_2  (operand_2),
        .illegal_op (illegal_op)
    );

    // ------------------------------------------------------
    // Adder controls
    // ------------------------------------------------------
    assign csr_mask = accuracy[apx_cfg_pkg::ACC_MASK_LSB +: APX_LEN]
                    & {APX_LEN{accuracy[apx_cfg_pkg::ACC_ENABLE_BIT]}};

    always_comb begin
        adder_a   = operand_1;
        adder_b   = operand_2;
        adder_cin = 1'b0;
        err_mask  = '0;                                   // Exact unless ADD/SUB
        case (alu_op)
            rv_isa_pkg::ALU_ADD: err_mask = csr_mask;
            rv_isa_pkg::ALU_SUB: begin                    // a + ~b + 1
                adder_b   = ~operand_2;
                adder_cin = 1'b1;
                err_mask  = csr_mask;
            end
            default: ;                                    // LINK, AUIPC stay exact
        endcase

        // Jumps and AUIPC must never see the CSR mask
        if (!(alu_op inside {rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SUB})) begin
            assert (err_mask == '0)
                else $error("adder mask set for non-arithmetic op %s", alu_op.name());
        end
    end

    apx_adder #(
        .LEN     (XLEN),
        .APX_LEN (APX_LEN)
    ) i_apx_adder (
        .a         (adder_a),
        .b         (adder_b),
        .carry_in  (adder_cin),
        .err_mask  (err_mask),
        .sum       (sum),
        .carry_out ()                                     // No flags in RV32I
    );

    // ------------------------------------------------------
    // Result select
    // ------------------------------------------------------
    assign shamt = operand_2[4:0];                        // RV32 shift amount

    always_comb begin
        case (alu_op)
            rv_isa_pkg::ALU_ADD,
            rv_isa_pkg::ALU_SUB,
            rv_isa_pkg::ALU_LINK,
            rv_isa_pkg::ALU_AUIPC: alu_result = sum;
            rv_isa_pkg::ALU_SLL:   alu_result = operand_1 << shamt;
            rv_isa_pkg::ALU_SRL:   alu_result = operand_1 >> shamt;
            rv_isa_pkg::ALU_SRA:   alu_result = $unsigned($signed(operand_1) >>> shamt);
            rv_isa_pkg::ALU_SLT:   alu_result = XLEN'($signed(operand_1) < $signed(operand_2));
            rv_isa_pkg::ALU_SLTU:  alu_result = XLEN'(operand_1 < operand_2);
            rv_isa_pkg::ALU_XOR:   alu_result = operand_1 ^ operand_2;
            rv_isa_pkg::ALU_OR:    alu_result = operand_1 | operand_2;
            rv_isa_pkg::ALU_AND:   alu_result = operand_1 & operand_2;
            default:               alu_result = '0;       // ALU_NONE
        endcase
    end

endmodule

/* hdl/alu_exec_stage.sv */
//----------------------------------------------------------
// Execute stage top: accuracy CSR plus one register stage
// after the ALU, one result per issue a cycle later
//----------------------------------------------------------
`timescale 1ns/1ps

module alu_exec_stage #(
    parameter int XLEN    = apx_cfg_pkg::XLEN,
    parameter int APX_LEN = apx_cfg_pkg::APX_LEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,                  // One strobe per instruction
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] immediate,
    input  logic            csr_write,                    // Accuracy CSR write strobe
    input  logic [XLEN-1:0] csr_wdata,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output logic            illegal
);

    logic [XLEN-1:0] accuracy_q;                          // Accuracy CSR
    logic [XLEN-1:0] alu_result;
    logic            alu_illegal;

    // ------------------------------------------------------
    // Accuracy CSR
    // ------------------------------------------------------
    // Same-edge issue still reads the old value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accuracy_q <= '0;                             // Exact after reset
        end else if (csr_write) begin
            accuracy_q <= csr_wdata;
        end
    end

    alu_apx #(
        .XLEN    (XLEN),
        .APX_LEN (APX_LEN)
    ) i_alu_apx (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .immediate  (immediate),
        .accuracy   (accuracy_q),
        .alu_result (alu_result),
        .illegal_op (alu_illegal)
    );

    // ------------------------------------------------------
    // Result register
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= issue_valid;                  // Single-cycle pulse per issue
            if (issue_valid) begin                        // Hold until next issue
                result  <= alu_result;
                illegal <= alu_illegal;
            end
        end
    end

    // A result pulse must trace back to an issue one edge earlier
    assert property (@(posedge clk) disable iff (!rst_n) !issue_valid |=> !result_valid)
        else $error("result_valid without a preceding issue");

endmodule

/* verif/alu_exec_clkgen.sv */
//----------------------------------------------------------
// Testbench clock of period 4 ns and synchronous reset
//----------------------------------------------------------
`timescale 1ns/1ps

module alu_exec_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                            // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);                       // Held for 16 cycles
        #1 rst_n = 1'b1;
    end

endmodule

/* verif/alu_exec_tb.sv */
//----------------------------------------------------------
// Testbench for the execute stage with random and directed
// issues, a reference model of the ALU and a result checker
//----------------------------------------------------------
`timescale 1ns/1ps

module alu_exec_tb;

    localparam int XLEN    = apx_cfg_pkg::XLEN;
    localparam int APX_LEN = apx_cfg_pkg::APX_LEN_DEFAULT;
    localparam logic [XLEN-1:0] SIGN_BIT = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    logic            csr_write;
    logic            result_valid;
    logic            illegal;
    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] immediate;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] result;

    logic [XLEN:0]   exp_q[$];                            // {illegal, result} per issue
    int              due_q[$];                            // Cycle the result must show up
    int              cycle = 0;
    int              errors = 0;
    int              checks = 0;
    bit              timed_out = 0;
    logic [XLEN-1:0] csr_now = '0;                        // CSR seen by the next issue
    logic [XLEN-1:0] csr_next = '0;
    logic [XLEN-1:0] last_result = '0;
    logic            last_illegal = 1'b0;

    alu_exec_clkgen i_clkgen (.clk(clk), .rst_n(rst_n));

    alu_exec_stage #(.XLEN(XLEN), .APX_LEN(APX_LEN)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .pc           (pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .immediate    (immediate),
        .csr_write    (csr_write),
        .csr_wdata    (csr_wdata),
        .result_valid (result_valid),
        .result       (result),
        .illegal      (illegal)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------------------------------
    // Reference model
    // ------------------------------------------------------
    function automatic logic [XLEN-1:0] approx_add(input logic [XLEN-1:0] a, b,
                                                   input logic cin,
                                                   input logic [APX_LEN-1:0] mask);
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] m;
        logic            c;
        m = XLEN'(mask);
        c = cin;
        for (int i = 0; i < XLEN; i++) begin
            if (m[i]) begin                               // OR sum and generate-only carry
                s[i] = a[i] | b[i];
                c    = a[i] & b[i];
            end else begin
                s[i] = a[i] ^ b[i] ^ c;
                c    = (a[i] & b[i]) | (a[i] & c) | (b[i] & c);
            end
        end
        return s;
    endfunction

    function automatic logic [XLEN-1:0] shift_right_arith(input logic [XLEN-1:0] a,
                                                          input logic [4:0] sh);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++)
            r[i] = (i + sh < XLEN) ? a[i+sh] : a[XLEN-1];  // Sign fills the top
        return r;
    endfunction

    function automatic logic [XLEN:0] alu_model(input logic [6:0] opc, input logic [2:0] f3,
                                                input logic [6:0] f7,
                                                input logic [XLEN-1:0] pc_v, rs1_v, rs2_v,
                                                input logic [XLEN-1:0] imm_v, csr_v);
        logic [APX_LEN-1:0] mask;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    res;
        logic               bad;
        logic               is_imm;
        logic               alt;
        logic               base_ok;
        mask = csr_v[apx_cfg_pkg::ACC_ENABLE_BIT] ? APX_LEN'(csr_v >> apx_cfg_pkg::ACC_MASK_LSB)
                                                  : '0;
        res  = '0;
        bad  = 1'b0;
        if (opc == rv_isa_pkg::OP || opc == rv_isa_pkg::OP_IMM) begin
            is_imm  = (opc == rv_isa_pkg::OP_IMM);
            b       = is_imm ? imm_v : rs2_v;
            alt     = !is_imm && f7 == rv_isa_pkg::F7_ALT;      // SUB only
            base_ok = is_imm || f7 == rv_isa_pkg::F7_BASE;
            case (f3)
                rv_isa_pkg::F3_ADD: begin
                    if (alt)          res = approx_add(rs1_v, ~b, 1'b1, mask);
                    else if (base_ok) res = approx_add(rs1_v, b, 1'b0, mask);
                    else              bad = 1'b1;
                end
                rv_isa_pkg::F3_SLL: begin
                    if (f7 == rv_isa_pkg::F7_BASE) res = rs1_v << b[4:0];
                    else                           bad = 1'b1;
                end
                rv_isa_pkg::F3_SR: begin
                    if (f7 == rv_isa_pkg::F7_BASE)     res = rs1_v >> b[4:0];
                    else if (f7 == rv_isa_pkg::F7_ALT) res = shift_right_arith(rs1_v, b[4:0]);
                    else                               bad = 1'b1;
                end
                default: begin                            // Compares and logic ops
                    bad = !base_ok;
                    case (f3)
                        rv_isa_pkg::F3_SLT:  res = XLEN'((rs1_v ^ SIGN_BIT) < (b ^ SIGN_BIT));
                        rv_isa_pkg::F3_SLTU: res = XLEN'(rs1_v < b);
                        rv_isa_pkg::F3_XOR:  res = rs1_v ^ b;
                        rv_isa_pkg::F3_OR:   res = rs1_v | b;
                        default:             res = rs1_v & b;
                    endcase
                end
            endcase
        end else if (opc == rv_isa_pkg::JAL || (opc == rv_isa_pkg::JALR && f3 == 3'b000)) begin
            res = pc_v + 32'd4;                           // Link value is never approximate
        end else if (opc == rv_isa_pkg::AUIPC) begin
            res = pc_v + imm_v;
        end else begin
            bad = 1'b1;
        end
        if (bad) res = '0;
        return {bad, res};
    endfunction

    // ------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------
    task automatic drive(input bit do_issue, input bit do_csr, input logic [XLEN-1:0] csr_data,
                         input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                         input logic [XLEN-1:0] pc_v, rs1_v, rs2_v, imm_v);
        @(posedge clk);
        #1;
        csr_now     = csr_next;                           // Write from last edge now active
        issue_valid = do_issue;
        opcode      = opc;
        funct3      = f3;
        funct7      = f7;
        pc          = pc_v;
        rs1         = rs1_v;
        rs2         = rs2_v;
        immediate   = imm_v;
        csr_write   = do_csr;
        csr_wdata   = csr_data;
        if (do_issue) begin
            exp_q.push_back(alu_model(opc, f3, f7, pc_v, rs1_v, rs2_v, imm_v, csr_now));
            due_q.push_back(cycle + 1);
        end
        if (do_csr) csr_next = csr_data;
    endtask

    task automatic issue(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                         input logic [XLEN-1:0] pc_v, rs1_v, rs2_v, imm_v);
        drive(1'b1, 1'b0, '0, opc, f3, f7, pc_v, rs1_v, rs2_v, imm_v);
    endtask

    task automatic write_csr(input logic [XLEN-1:0] data);
        drive(1'b0, 1'b1, data, '0, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic idle();
        drive(1'b0, 1'b0, '0, '0, '0, '0, '0, '0, '0, '0);
    endtask

    // Back-to-back random issues of one encoding
    task automatic run_op(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                          input int count);
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] im;
        for (int n = 0; n < count; n++) begin
            r1 = $urandom;
            im = $urandom;
            if (n % 2 == 0) r1[XLEN-1] = 1'b1;          // Negative rs1 every other issue
            if (opc == rv_isa_pkg::OP_IMM) im = {{20{im[11]}}, im[11:0]};
            issue(opc, f3, f7, $urandom, r1, $urandom, im);
        end
        idle();
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------
    // Checker
    // ------------------------------------------------------
    always @(negedge clk) begin : compare_results
        logic [XLEN:0] expected;
        int            due;
        if (rst_n) begin
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("result_valid pulsed with no instruction outstanding");
                end else begin
                    expected = exp_q.pop_front();
                    due      = due_q.pop_front();
                    if (cycle != due) begin               // Exactly one cycle after issue
                        errors++;
                        $display("result arrived in cycle %0d instead of %0d", cycle, due);
                    end
                    check_value("result", result, expected[XLEN-1:0]);
                    check_value("illegal", XLEN'(illegal), XLEN'(expected[XLEN]));
                end
                last_result  = result;
                last_illegal = illegal;
            end else begin                                // Outputs hold between results
                check_value("result", result, last_result);
                check_value("illegal", XLEN'(illegal), XLEN'(last_illegal));
            end
        end
    end

    // ------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------
    task automatic run_tests();
        logic [XLEN-1:0] pc_v;
        // Exact arithmetic out of reset
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 0, 32'hFFFF_FFFF, 1, 0);
        run_op(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 4);
        run_op(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 4);
        run_op(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_ALT, 4);
        // Logic, shift and compare in register and immediate forms
        for (int f = 1; f < 8; f++) begin
            run_op(rv_isa_pkg::OP, 3'(f), rv_isa_pkg::F7_BASE, 8);
            run_op(rv_isa_pkg::OP_IMM, 3'(f), rv_isa_pkg::F7_BASE, 8);
        end
        run_op(rv_isa_pkg::OP, rv_isa_pkg::F3_SR, rv_isa_pkg::F7_ALT, 8);      // SRA
        run_op(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SR, rv_isa_pkg::F7_ALT, 8);  // SRAI
        // Sign boundary where signed and unsigned disagree
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_SLT, rv_isa_pkg::F7_BASE, 0, 32'h7FFF_FFFF,
              32'h8000_0000, 0);
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_SLTU, rv_isa_pkg::F7_BASE, 0, 32'h7FFF_FFFF,
              32'h8000_0000, 0);
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_SLT, rv_isa_pkg::F7_BASE, 0, 32'h8000_0000,
              32'h7FFF_FFFF, 0);
        issue(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLT, 0, 0, 32'h7FFF_FFFF, 0, 32'hFFFF_FFFF);
        issue(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLTU, 0, 0, 32'h7FFF_FFFF, 0, 32'hFFFF_FFFF);
        idle();
        // Jumps and AUIPC with full approximation enabled
        write_csr(32'hFFFF_FFFF);
        for (int n = 0; n < 6; n++) begin
            pc_v = $urandom | 32'h0000_00FC;              // Forces carries in the low byte
            issue(rv_isa_pkg::JAL, 3'($urandom), 0, pc_v, $urandom, $urandom, $urandom);
            issue(rv_isa_pkg::JALR, 3'b000, 0, pc_v, $urandom, $urandom, $urandom);
            issue(rv_isa_pkg::AUIPC, 0, 0, pc_v, $urandom, $urandom, $urandom);
        end
        idle();
        // Random masks with enable set then clear
        for (int n = 0; n < 11; n++) begin
            if (n < 8) write_csr($urandom | 32'h1);
            else       write_csr(($urandom | 32'h0000_03FC) & ~32'h1);
            run_op(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 3);
            run_op(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 3);
            run_op(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_ALT, 3);
        end
        // Illegal encodings
        issue(rv_isa_pkg::LOAD, 3'b010, 0, 32'h100, $urandom, $urandom, $urandom);
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, 7'h01, 0, $urandom, $urandom, 0);
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_XOR, rv_isa_pkg::F7_ALT, 0, $urandom, $urandom, 0);
        issue(rv_isa_pkg::JALR, 3'b001, 0, 32'h200, $urandom, 0, 0);
        issue(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLL, rv_isa_pkg::F7_ALT, 0, $urandom, 0, 3);
        idle();
        // CSR write on the same edge as an issue
        write_csr(0);
        drive(1'b1, 1'b1, 32'h0000_03FD, rv_isa_pkg::OP, rv_isa_pkg::F3_ADD,
              rv_isa_pkg::F7_BASE, 0, 32'hFF, 32'h1, 0);
        issue(rv_isa_pkg::OP, rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 0, 32'hFF, 32'h1, 0);
        idle();
    endtask

    initial begin
        void'($urandom(98));
        issue_valid = 1'b0;
        opcode      = '0;
        funct3      = '0;
        funct7      = '0;
        pc          = '0;
        rs1         = '0;
        rs2         = '0;
        immediate   = '0;
        csr_write   = 1'b0;
        csr_wdata   = '0;
        for (int n = 0; n < 50 && rst_n !== 1'b1; n++) @(posedge clk);
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end else begin
            @(negedge clk);
            check_value("result_valid", XLEN'(result_valid), '0);
            check_value("result", result, '0);
            check_value("illegal", XLEN'(illegal), '0);
            run_tests();
            for (int n = 0; n < 50 && exp_q.size() != 0; n++) @(posedge clk);
            if (exp_q.size() != 0) begin
                timed_out = 1'b1;
                $display("timeout: %0d results never arrived", exp_q.size());
            end
        end
        @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* alu_exec_stage.f */
hdl/rv_isa_pkg.sv
hdl/apx_cfg_pkg.sv
hdl/operand_select.sv
hdl/apx_adder.sv
hdl/alu_apx.sv
hdl/alu_exec_stage.sv
verif/alu_exec_clkgen.sv
verif/alu_exec_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

SRCS := $(shell cat alu_exec_stage.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Valu_exec_tb: alu_exec_stage.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--timescale 1ns/1ps \
		--top-module alu_exec_tb \
		-f alu_exec_stage.f

# The log decides the outcome
run: obj_dir/Valu_exec_tb
	./obj_dir/Valu_exec_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
